/* common/xbar_cfg_pkg.sv */
package xbar_cfg_pkg;

    //////////////////////////////////////////////////
    // Switch dimensions
    //////////////////////////////////////////////////

    // Ports per side, inputs and outputs alike
    localparam int XBAR_PORTS = 4;

    localparam int XBAR_DW    = 8;  // Bits per port data
    localparam int XBAR_IDX_W = 2;  // Enough to name any port

    // Index must reach every port
    // 2**XBAR_IDX_W >= XBAR_PORTS

endpackage

/* common/xbar_types_pkg.sv */
package xbar_types_pkg;

    import xbar_cfg_pkg::*;

    //////////////////////////////////////////////////
    // Scalar and per-port types
    //////////////////////////////////////////////////

    typedef logic [XBAR_DW-1:0]    xbar_data_t;  // One port's byte
    typedef logic [XBAR_IDX_W-1:0] xbar_idx_t;   // Port number

    typedef logic [XBAR_PORTS-1:0]   xbar_vec_t;       // One bit per port
    typedef xbar_vec_t [XBAR_PORTS-1:0] xbar_tmat_t;   // [input][output]
    typedef xbar_data_t [XBAR_PORTS-1:0] xbar_data_vec_t;
    typedef xbar_idx_t [XBAR_PORTS-1:0]  xbar_idx_vec_t;

    //////////////////////////////////////////////////
    // Stage payloads
    //////////////////////////////////////////////////

    // Ingress register contents
    typedef struct packed {
        xbar_tmat_t     tgt;    // One-hot targets, already gated by valid
        xbar_vec_t      valid;  // Per input request
        xbar_data_vec_t data;   // Per input byte
    } xbar_ingress_t;

    // Routed result, per output except drop
    typedef struct packed {
        xbar_vec_t      valid;  // Output got a winner
        xbar_data_vec_t data;
        xbar_idx_vec_t  src;    // Winning input
        xbar_vec_t      drop;   // Per input, lost arbitration
    } xbar_result_t;

endpackage

/* common/xbar_route_if.sv */
`timescale 1ns/1ps

// Ingress to crosspoint link
interface xbar_route_if
    import xbar_types_pkg::*;
();

    xbar_tmat_t     tgt;    // Target matrix, input by output
    xbar_vec_t      valid;  // Registered request strobes
    xbar_data_vec_t data;   // Registered bytes
    logic           en;     // Pipeline advance level

    // Ingress side
    modport src (
        output tgt,
        output valid,
        output data,
        output en
    );

    // Core side
    modport dst (
        input tgt,
        input valid,
        input data,
        input en
    );

endinterface

/* rtl/xbar_stage_reg.sv */
`timescale 1ns/1ps

// Generic pipeline stage
// Loads on en, clears asynchronously
module xbar_stage_reg #(
    parameter type payload_t = logic  // Any packed payload
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,   // Stall when low
    input  payload_t d,
    output payload_t q
);

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;  // Everything back to zero
        end else if (en) begin
            q <= d;
        end
        // Otherwise hold
    end

endmodule

/* rtl/xbar_ingress.sv */
`timescale 1ns/1ps

// Request sampling and destination decode
module xbar_ingress
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           en,
    input  xbar_vec_t      in_valid,  // Request strobes
    input  xbar_idx_vec_t  in_dest,   // Target output per input
    input  xbar_data_vec_t in_data,
    xbar_route_if.src      route
);

    xbar_ingress_t ing_d;  // Decoded, not yet registered
    xbar_ingress_t ing_q;

    //////////////////////////////////////////////////
    // Destination decode
    //////////////////////////////////////////////////

    always_comb begin
        ing_d.valid = in_valid;
        ing_d.data  = in_data;
        for (int i = 0; i < XBAR_PORTS; i++) begin
            for (int o = 0; o < XBAR_PORTS; o++) begin
                // One-hot, empty when no request
                ing_d.tgt[i][o] = in_valid[i] && (in_dest[i] == xbar_idx_t'(o));
            end
        end
    end

    // First pipeline stage
    xbar_stage_reg #(
        .payload_t (xbar_ingress_t)
    ) u_ing_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .d     (ing_d),
        .q     (ing_q)
    );

    // Drive the link
    assign route.tgt   = ing_q.tgt;
    assign route.valid = ing_q.valid;
    assign route.data  = ing_q.data;
    assign route.en    = en;  // Core sees same stall

endmodule

/* xbar_core/xbar_prio_arbiter.sv */
`timescale 1ns/1ps

// Fixed priority, lowest input wins
// Purely combinational
module xbar_prio_arbiter
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    input  xbar_tmat_t    target,   // [input][output] requests
    output xbar_tmat_t    grant,    // [input][output] winners
    output xbar_idx_vec_t win_idx,  // Winner per output
    output xbar_vec_t     win_any,  // Output has any requester
    output xbar_vec_t     drop      // Per input, requested but lost
);

    //////////////////////////////////////////////////
    // Per-output resolution
    //////////////////////////////////////////////////

    always_comb begin
        logic found;  // Winner seen for this column

        grant   = '0;
        win_idx = '0;
        win_any = '0;
        found   = 1'b0;

        for (int o = 0; o < XBAR_PORTS; o++) begin
            found = 1'b0;
            // Scan upward, first hit sticks
            for (int i = 0; i < XBAR_PORTS; i++) begin
                if (target[i][o] && !found) begin
                    found       = 1'b1;
                    grant[i][o] = 1'b1;
                    win_idx[o]  = xbar_idx_t'(i);
                end
            end
            win_any[o] = found;
        end
    end

    //////////////////////////////////////////////////
    // Losers
    //////////////////////////////////////////////////

    // Row nonzero means the input was valid
    always_comb begin
        for (int i = 0; i < XBAR_PORTS; i++) begin
            drop[i] = (|target[i]) && !(|grant[i]);  // Asked, got nothing
        end
    end

endmodule

/* xbar_core/xbar_crosspoint.sv */
`timescale 1ns/1ps

// Routing core
// Arbitrates each output and steers the winning byte
module xbar_crosspoint
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    xbar_route_if.dst    route,
    output xbar_result_t result  // To egress register
);

    xbar_idx_vec_t win_idx;   // Winning input per output
    xbar_vec_t     win_any;   // Output has a winner
    xbar_vec_t     arb_drop;  // Per input, lost

    //////////////////////////////////////////////////
    // Arbitration
    //////////////////////////////////////////////////

    xbar_prio_arbiter u_arb (
        .target  (route.tgt),
        .grant   (),
        .win_idx (win_idx),
        .win_any (win_any),
        .drop    (arb_drop)
    );

    //////////////////////////////////////////////////
    // Data steering
    //////////////////////////////////////////////////

    always_comb begin
        result.valid = win_any;
        result.drop  = arb_drop;
        for (int o = 0; o < XBAR_PORTS; o++) begin
            // Idle outputs pick input 0, egress holds them anyway
            result.data[o] = route.data[win_idx[o]];
            result.src[o]  = win_idx[o];  // Source index travels along
        end
    end

endmodule

/* rtl/xbar_egress.sv */
`timescale 1ns/1ps

// Output stage
// Holds last routed byte, pulses valid on new routes
module xbar_egress
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           en,
    input  xbar_result_t   result,     // Combinational from core
    output xbar_vec_t      out_valid,
    output xbar_data_vec_t out_data,
    output xbar_idx_vec_t  out_src,
    output xbar_vec_t      drop
);

    xbar_result_t res_d;  // After hold substitution
    xbar_result_t res_q;

    //////////////////////////////////////////////////
    // Hold idle outputs
    //////////////////////////////////////////////////

    always_comb begin
        res_d = result;  // Valid and drop pass as is
        for (int o = 0; o < XBAR_PORTS; o++) begin
            if (!result.valid[o]) begin
                // No route, keep what was last sent
                res_d.data[o] = res_q.data[o];
                res_d.src[o]  = res_q.src[o];
            end
        end
    end

    // Second pipeline stage
    xbar_stage_reg #(
        .payload_t (xbar_result_t)
    ) u_res_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .d     (res_d),
        .q     (res_q)
    );

    assign out_valid = res_q.valid;  // One enabled cycle per route
    assign out_data  = res_q.data;
    assign out_src   = res_q.src;
    assign drop      = res_q.drop;

endmodule

/* rtl/xbar_top.sv */
`timescale 1ns/1ps

// 4x4 priority crossbar
// Ingress, core and egress, two enabled edges end to end
module xbar_top
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 en,        // Global stall when low
    input  logic [XBAR_PORTS-1:0]                in_valid,
    input  logic [XBAR_PORTS-1:0][XBAR_IDX_W-1:0] in_dest,
    input  logic [XBAR_PORTS-1:0][XBAR_DW-1:0]    in_data,
    output logic [XBAR_PORTS-1:0]                out_valid,
    output logic [XBAR_PORTS-1:0][XBAR_DW-1:0]    out_data,
    output logic [XBAR_PORTS-1:0][XBAR_IDX_W-1:0] out_src,
    output logic [XBAR_PORTS-1:0]                drop       // Per input, lost
);

    //////////////////////////////////////////////////
    // Internal links
    //////////////////////////////////////////////////

    xbar_route_if u_route ();  // Ingress to core

    xbar_result_t routed;      // Core to egress, combinational

    //////////////////////////////////////////////////
    // Pipeline
    //////////////////////////////////////////////////

    // Stage 1, sample and decode
    xbar_ingress u_ingress (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .in_valid (in_valid),
        .in_dest  (in_dest),
        .in_data  (in_data),
        .route    (u_route)
    );

    // Arbitrate and steer
    xbar_crosspoint u_crosspoint (
        .route  (u_route),
        .result (routed)
    );

    // Stage 2, register results
    xbar_egress u_egress (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .result    (routed),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_src   (out_src),
        .drop      (drop)
    );

endmodule

/* test/tb_xbar_top.sv */
`timescale 1ns/1ps

// Testbench for the 4x4 priority crossbar
// Reference model runs two enabled edges behind the inputs
module tb_xbar_top
    import xbar_cfg_pkg::*;
();

    logic                                  clk;
    logic                                  rst_n;
    logic                                  en;
    logic [XBAR_PORTS-1:0]                 in_valid;
    logic [XBAR_PORTS-1:0][XBAR_IDX_W-1:0] in_dest;
    logic [XBAR_PORTS-1:0][XBAR_DW-1:0]    in_data;
    logic [XBAR_PORTS-1:0]                 out_valid;
    logic [XBAR_PORTS-1:0][XBAR_DW-1:0]    out_data;
    logic [XBAR_PORTS-1:0][XBAR_IDX_W-1:0] out_src;
    logic [XBAR_PORTS-1:0]                 drop;

    // Model state, stage 1 then expected outputs
    logic [XBAR_PORTS-1:0]                 m_valid;
    logic [XBAR_PORTS-1:0][XBAR_IDX_W-1:0] m_dest;
    logic [XBAR_PORTS-1:0][XBAR_DW-1:0]    m_data;
    logic [XBAR_PORTS-1:0]                 exp_valid;
    logic [XBAR_PORTS-1:0][XBAR_DW-1:0]    exp_data;
    logic [XBAR_PORTS-1:0][XBAR_IDX_W-1:0] exp_src;
    logic [XBAR_PORTS-1:0]                 exp_drop;

    int errors = 0;
    int checks = 0;
    int seed   = 32'hef609508;  // Fixed for repeatable traffic

    xbar_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .in_valid  (in_valid),
        .in_dest   (in_dest),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_src   (out_src),
        .drop      (drop)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    always @(posedge clk or negedge rst_n) begin : ref_model
        logic [XBAR_PORTS-1:0] granted;  // Inputs that won somewhere
        logic                  found;
        int                    win;

        if (!rst_n) begin
            m_valid   <= '0;
            m_dest    <= '0;
            m_data    <= '0;
            exp_valid <= '0;
            exp_data  <= '0;
            exp_src   <= '0;
            exp_drop  <= '0;
        end else if (en) begin
            granted = '0;
            for (int o = 0; o < XBAR_PORTS; o++) begin
                found = 1'b0;
                win   = 0;
                // Lowest requester takes the output
                for (int i = 0; i < XBAR_PORTS; i++) begin
                    if (!found && m_valid[i] && int'(m_dest[i]) == o) begin
                        found = 1'b1;
                        win   = i;
                    end
                end
                exp_valid[o] <= found;
                if (found) begin
                    granted[win] = 1'b1;
                    exp_data[o]  <= m_data[win];
                    exp_src[o]   <= win[XBAR_IDX_W-1:0];
                end  // Else last value stays
            end
            exp_drop <= m_valid & ~granted;  // Asked, lost
            m_valid  <= in_valid;            // Next request in
            m_dest   <= in_dest;
            m_data   <= in_data;
        end
    end

    //////////////////////////////////////////////////
    // Checks, mid-cycle where all is settled
    //////////////////////////////////////////////////

    a_out_valid: assert property (@(negedge clk) out_valid == exp_valid)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: out_valid %b, expected %b",
                     $time, out_valid, exp_valid);
        end

    a_out_data: assert property (@(negedge clk) out_data == exp_data)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: out_data %h, expected %h",
                     $time, out_data, exp_data);
        end

    a_out_src: assert property (@(negedge clk) out_src == exp_src)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: out_src %h, expected %h",
                     $time, out_src, exp_src);
        end

    a_drop: assert property (@(negedge clk) drop == exp_drop)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: drop %b, expected %b",
                     $time, drop, exp_drop);
        end

    always @(negedge clk) begin
        checks = checks + 4;  // Four assertions per cycle
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // Inputs move shortly after the rising edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_requests();
        in_valid = '0;
        in_dest  = '0;
        in_data  = '0;
    endtask

    // One request set, held for a single edge
    task automatic drive_requests(
        input logic [XBAR_PORTS-1:0]                 v,
        input logic [XBAR_PORTS-1:0][XBAR_IDX_W-1:0] d,
        input logic [XBAR_PORTS-1:0][XBAR_DW-1:0]    dat
    );
        tick();
        in_valid = v;
        in_dest  = d;
        in_data  = dat;
        tick();
        clear_requests();
    endtask

    // Poll out_valid, give up after limit cycles
    task automatic wait_for_outputs(input logic [XBAR_PORTS-1:0] mask, input int limit);
        int n;

        n = 0;
        @(negedge clk);
        while ((out_valid & mask) != mask && n < limit) begin
            @(negedge clk);
            n++;
        end
        if ((out_valid & mask) != mask) begin
            errors++;
            $display("Timed out at %0t after %0d cycles waiting for out_valid %b",
                     $time, limit, mask);
        end
    endtask

    task automatic run_random(input int cycles);
        logic [31:0] r;

        for (int n = 0; n < cycles; n++) begin
            tick();
            r        = $random(seed);
            in_valid = r[3:0];
            in_dest  = r[11:4];
            en       = (r[13:12] != 2'b00);  // Stall about a quarter
            r        = $random(seed);
            in_data  = r;
        end
        tick();
        clear_requests();
        en = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        rst_n = 1'b0;
        en    = 1'b1;
        clear_requests();
        repeat (10) @(posedge clk);  // Reset check runs meanwhile
        #2;
        rst_n = 1'b1;
        repeat (2) tick();

        // Permutation, every output served
        drive_requests(4'hf, {2'd2, 2'd1, 2'd3, 2'd0}, {8'h44, 8'h33, 8'h22, 8'h11});
        wait_for_outputs(4'hf, 4);

        // Three inputs fight for output 2
        drive_requests(4'b1110, {2'd2, 2'd2, 2'd2, 2'd0}, {8'hd4, 8'hc3, 8'hb2, 8'ha1});
        wait_for_outputs(4'b0100, 4);
        // Input 0 beats 1 and 3 on output 1
        drive_requests(4'b1011, {2'd1, 2'd0, 2'd1, 2'd1}, {8'h5d, 8'h5c, 8'h5b, 8'h5a});
        wait_for_outputs(4'b0010, 4);

        // Only output 3 moves, rest hold
        drive_requests(4'b0001, {2'd0, 2'd0, 2'd0, 2'd3}, {8'h00, 8'h00, 8'h00, 8'h7e});
        wait_for_outputs(4'b1000, 4);
        repeat (3) tick();

        // Offered while stalled, nothing may come out
        tick();
        en       = 1'b0;
        in_valid = 4'hf;
        in_dest  = {2'd0, 2'd1, 2'd2, 2'd3};
        in_data  = {8'he4, 8'he3, 8'he2, 8'he1};
        repeat (3) tick();
        clear_requests();
        en = 1'b1;
        repeat (4) tick();

        // Stall hits with a request in stage 1
        drive_requests(4'b0110, {2'd0, 2'd3, 2'd0, 2'd0}, {8'h00, 8'h96, 8'h95, 8'h00});
        en = 1'b0;
        repeat (3) tick();
        en = 1'b1;
        wait_for_outputs(4'b1001, 4);

        run_random(400);
        repeat (3) tick();  // Drain the pipeline

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
common/xbar_cfg_pkg.sv
common/xbar_types_pkg.sv
common/xbar_route_if.sv
rtl/xbar_stage_reg.sv
rtl/xbar_ingress.sv
xbar_core/xbar_prio_arbiter.sv
xbar_core/xbar_crosspoint.sv
rtl/xbar_egress.sv
rtl/xbar_top.sv
test/tb_xbar_top.sv

/* Makefile */
# Verilator flow for the crossbar testbench

TOP := tb_xbar_top
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)

# Pass only when the log holds the pass line
run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
